//--- hdl/eth_mon_pkg.sv
package eth_mon_pkg;

    // stream geometry, one 32-bit word per beat
    localparam int STREAM_DATA_W = 32;
    localparam int STREAM_KEEP_W = 2;

    // capture memory geometry
    localparam int BUF_DEPTH  = 1024;
    localparam int BUF_ADDR_W = 10;
    // captured length runs from 0 up to BUF_DEPTH inclusive
    localparam int CAP_LEN_W  = BUF_ADDR_W + 1;

    // host register port
    localparam int REG_ADDR_W  = 16;
    localparam int REG_DATA_W  = 40;
    localparam int REG_WIN_BIT = REG_ADDR_W - 1;

    localparam logic [REG_ADDR_W-1:0] REG_ADDR_PKT_COUNT = 16'h0000;
    localparam logic [REG_ADDR_W-1:0] REG_ADDR_TRIGGER   = 16'h0001;
    localparam logic [REG_ADDR_W-1:0] REG_ADDR_CAP_LEN   = 16'h0002;

    // one captured beat as stored in the buffer
    typedef struct packed {
        logic [STREAM_DATA_W-1:0] data;
        logic [STREAM_KEEP_W-1:0] keep;
        logic                     abort;
        logic                     last;
    } buf_row_t;

    // buffer row as seen through the register window
    typedef struct packed {
        logic [3:0] pad;
        buf_row_t   row;
    } reg_row_view_t;

    // read word is either a counter value or a buffer row
    typedef union packed {
        logic [REG_DATA_W-1:0] count;
        reg_row_view_t         row_view;
    } reg_word_u;

endpackage

//--- hdl/eth_mon_ifs.sv
`timescale 1ns/1ns

// registered stream beat plus packet framing state
interface eth_stream_if;
    import eth_mon_pkg::*;

    logic [STREAM_DATA_W-1:0] data;
    logic [STREAM_KEEP_W-1:0] keep;
    logic                     valid;
    logic                     abort;
    logic                     last;
    // no packet open before the current beat
    logic                     bus_idle;

    modport src (output data, keep, valid, abort, last, bus_idle);
    modport snk (input  data, keep, valid, abort, last, bus_idle);

endinterface

// single access port onto the capture buffer
interface buf_port_if;
    import eth_mon_pkg::*;

    logic                  req;
    logic                  we;
    logic [BUF_ADDR_W-1:0] addr;
    buf_row_t              wdata;
    logic                  gnt;
    buf_row_t              rdata;
    logic                  rvalid;

    modport req_side (
        output req, we, addr, wdata,
        input  gnt, rdata, rvalid
    );

    modport grant_side (
        input  req, we, addr, wdata,
        output gnt, rdata, rvalid
    );

endinterface

//--- hdl/stream_tap.sv
`timescale 1ns/1ns

module stream_tap (
    input  logic                                  i_clk_stream,
    input  logic                                  i_rst_n,
    input  logic [eth_mon_pkg::STREAM_DATA_W-1:0] i_eths_slave_data,
    input  logic [eth_mon_pkg::STREAM_KEEP_W-1:0] i_eths_slave_keep,
    input  logic                                  i_eths_slave_valid,
    input  logic                                  i_eths_slave_abort,
    input  logic                                  i_eths_slave_last,
    output logic [eth_mon_pkg::STREAM_DATA_W-1:0] o_eths_master_data,
    output logic [eth_mon_pkg::STREAM_KEEP_W-1:0] o_eths_master_keep,
    output logic                                  o_eths_master_valid,
    output logic                                  o_eths_master_abort,
    output logic                                  o_eths_master_last,
    eth_stream_if.src                             o_stream,
    output logic [eth_mon_pkg::REG_DATA_W-1:0]    o_pkt_count
);
    import eth_mon_pkg::*;

    logic [STREAM_DATA_W-1:0] data_q;
    logic [STREAM_KEEP_W-1:0] keep_q;
    logic                     valid_q;
    logic                     abort_q;
    logic                     last_q;
    logic                     bus_idle_q;
    logic [REG_DATA_W-1:0]    pkt_count_q;

    // payload of the passthrough stage
    always_ff @(posedge i_clk_stream) begin
        data_q <= i_eths_slave_data;
        keep_q <= i_eths_slave_keep;
    end

    always_ff @(posedge i_clk_stream or negedge i_rst_n) begin
        if (!i_rst_n) begin
            valid_q     <= 1'b0;
            abort_q     <= 1'b0;
            last_q      <= 1'b0;
            bus_idle_q  <= 1'b1;
            pkt_count_q <= '0;
        end else begin
            valid_q <= i_eths_slave_valid;
            abort_q <= i_eths_slave_abort;
            last_q  <= i_eths_slave_last;
            // a packet stays open until its last beat goes by
            if (valid_q) begin
                bus_idle_q <= last_q;
            end
            // saturate rather than wrap
            if (valid_q && last_q && (pkt_count_q != '1)) begin
                pkt_count_q <= pkt_count_q + 1'b1;
            end
        end
    end

    assign o_eths_master_data  = data_q;
    assign o_eths_master_keep  = keep_q;
    assign o_eths_master_valid = valid_q;
    assign o_eths_master_abort = abort_q;
    assign o_eths_master_last  = last_q;

    assign o_stream.data     = data_q;
    assign o_stream.keep     = keep_q;
    assign o_stream.valid    = valid_q;
    assign o_stream.abort    = abort_q;
    assign o_stream.last     = last_q;
    assign o_stream.bus_idle = bus_idle_q;

    assign o_pkt_count = pkt_count_q;

endmodule

//--- hdl/capture_ctrl.sv
`timescale 1ns/1ns

module capture_ctrl (
    input  logic                              i_clk_stream,
    input  logic                              i_rst_n,
    eth_stream_if.snk                         i_stream,
    buf_port_if.req_side                      o_buf,
    input  logic                              i_arm,
    output logic                              o_armed,
    output logic [eth_mon_pkg::CAP_LEN_W-1:0] o_cap_len
);
    import eth_mon_pkg::*;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_WAITING,
        ST_CAPTURING,
        ST_DONE
    } cap_state_t;

    cap_state_t           state_q;
    logic [CAP_LEN_W-1:0] row_cnt_q;
    logic [CAP_LEN_W-1:0] cap_len_q;
    logic                 start;
    logic                 beat;
    logic                 row_free;
    logic                 wr_en;

    // capture only begins on a beat that opens a new packet
    assign start    = (state_q == ST_WAITING) && i_stream.valid && i_stream.bus_idle;
    assign beat     = start || ((state_q == ST_CAPTURING) && i_stream.valid);
    // beats past the last row are dropped
    // the capture still ends on the packet's last beat
    assign row_free = (row_cnt_q < CAP_LEN_W'(BUF_DEPTH));
    assign wr_en    = beat && row_free;

    assign o_buf.req   = wr_en;
    assign o_buf.we    = wr_en;
    assign o_buf.addr  = row_cnt_q[BUF_ADDR_W-1:0];
    assign o_buf.wdata = {i_stream.data, i_stream.keep, i_stream.abort, i_stream.last};

    assign o_armed   = (state_q == ST_WAITING) || (state_q == ST_CAPTURING);
    assign o_cap_len = cap_len_q;

    always_ff @(posedge i_clk_stream or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state_q   <= ST_IDLE;
            row_cnt_q <= '0;
            cap_len_q <= '0;
        end else begin
            if (wr_en) begin
                row_cnt_q <= row_cnt_q + 1'b1;
            end
            case (state_q)
                ST_IDLE: begin
                    if (i_arm) begin
                        state_q   <= ST_WAITING;
                        row_cnt_q <= '0;
                    end
                end
                ST_WAITING: begin
                    if (start) begin
                        state_q <= i_stream.last ? ST_DONE : ST_CAPTURING;
                    end
                end
                ST_CAPTURING: begin
                    if (beat && i_stream.last) begin
                        state_q <= ST_DONE;
                    end
                end
                ST_DONE: begin
                    // row count now equals the number of rows written
                    cap_len_q <= row_cnt_q;
                    if (i_arm) begin
                        state_q   <= ST_WAITING;
                        row_cnt_q <= '0;
                    end else begin
                        state_q <= ST_IDLE;
                    end
                end
                default: state_q <= ST_IDLE;
            endcase
        end
    end

    // writes are never held off by the arbiter
    a_wr_granted: assert property (@(posedge i_clk_stream) disable iff (!i_rst_n)
        o_buf.req |-> o_buf.gnt);

    // row 0 takes the opening beat of a packet and later rows stay inside that packet
    a_wr_in_capture: assert property (@(posedge i_clk_stream) disable iff (!i_rst_n)
        o_buf.req |-> ((row_cnt_q == '0) == i_stream.bus_idle));

endmodule

//--- hdl/buffer_arbiter.sv
`timescale 1ns/1ns

module buffer_arbiter (
    input  logic           i_clk_stream,
    input  logic           i_rst_n,
    buf_port_if.grant_side i_wr,
    buf_port_if.grant_side i_rd,
    buf_port_if.req_side   o_mem
);

    logic rd_sel_q;

    // writer has fixed priority since the stream cannot be stalled
    assign o_mem.req   = i_wr.req || i_rd.req;
    assign o_mem.we    = i_wr.req ? i_wr.we    : i_rd.we;
    assign o_mem.addr  = i_wr.req ? i_wr.addr  : i_rd.addr;
    assign o_mem.wdata = i_wr.req ? i_wr.wdata : i_rd.wdata;

    assign i_wr.gnt = i_wr.req && o_mem.gnt;
    assign i_rd.gnt = i_rd.req && !i_wr.req && o_mem.gnt;

    // remembers who owns the read data coming back next cycle
    always_ff @(posedge i_clk_stream or negedge i_rst_n) begin
        if (!i_rst_n) begin
            rd_sel_q <= 1'b0;
        end else begin
            rd_sel_q <= i_rd.gnt;
        end
    end

    assign i_rd.rdata  = o_mem.rdata;
    assign i_wr.rdata  = o_mem.rdata;
    assign i_rd.rvalid = rd_sel_q && o_mem.rvalid;
    assign i_wr.rvalid = !rd_sel_q && o_mem.rvalid;

    a_one_grant: assert property (@(posedge i_clk_stream) disable iff (!i_rst_n)
        !(i_wr.gnt && i_rd.gnt) && !(i_rd.gnt && i_wr.req));

    // a reader grant always produces read data from the buffer one cycle later
    a_rd_returns: assert property (@(posedge i_clk_stream) disable iff (!i_rst_n)
        i_rd.gnt && !i_rd.we |=> i_rd.rvalid);

endmodule

//--- hdl/capture_buffer.sv
`timescale 1ns/1ns

module capture_buffer (
    input  logic           i_clk_stream,
    buf_port_if.grant_side i_port
);
    import eth_mon_pkg::*;

    buf_row_t mem_q [BUF_DEPTH];
    logic     rvalid_q;

    // single port, every enabled access is taken at once
    assign i_port.gnt = i_port.req;

    always_ff @(posedge i_clk_stream) begin
        if (i_port.req) begin
            if (i_port.we) begin
                mem_q[i_port.addr] <= i_port.wdata;
            end else begin
                i_port.rdata <= mem_q[i_port.addr];
            end
        end
        rvalid_q <= i_port.req && !i_port.we;
    end

    assign i_port.rvalid = rvalid_q;

    a_we_needs_en: assert property (@(posedge i_clk_stream)
        i_port.we |-> i_port.req);

endmodule

//--- hdl/reg_access.sv
`timescale 1ns/1ns

module reg_access (
    input  logic                               i_clk_stream,
    input  logic                               i_rst_n,
    input  logic [eth_mon_pkg::REG_ADDR_W-1:0] i_reg_addr,
    input  logic                               i_reg_rd,
    input  logic                               i_reg_wr,
    output logic [eth_mon_pkg::REG_DATA_W-1:0] o_reg_rdata,
    output logic                               o_reg_valid,
    input  logic [eth_mon_pkg::REG_DATA_W-1:0] i_pkt_count,
    input  logic                               i_armed,
    input  logic [eth_mon_pkg::CAP_LEN_W-1:0]  i_cap_len,
    output logic                               o_arm,
    buf_port_if.req_side                       o_buf
);
    import eth_mon_pkg::*;

    typedef enum logic [1:0] {
        RD_IDLE,
        RD_REQ,
        RD_WAIT
    } rd_state_t;

    rd_state_t             rd_state_q;
    logic                  valid_q;
    reg_word_u             rdata_q;
    reg_word_u             word_d;
    logic [BUF_ADDR_W-1:0] row_addr_q;
    logic                  req_seen;
    logic                  is_window;
    logic                  buf_start;
    logic                  load_word;

    // host keeps its request up while valid is out, so ignore that cycle
    assign req_seen  = (i_reg_rd || i_reg_wr) && !valid_q && (rd_state_q == RD_IDLE);
    assign is_window = i_reg_addr[REG_WIN_BIT];
    assign buf_start = req_seen && i_reg_rd && is_window;
    assign load_word = (req_seen && !buf_start) || ((rd_state_q == RD_WAIT) && o_buf.rvalid);

    assign o_arm = req_seen && i_reg_wr && (i_reg_addr == REG_ADDR_TRIGGER);

    always_comb begin
        word_d = '0;
        if (rd_state_q == RD_WAIT) begin
            word_d.row_view.row = o_buf.rdata;
        end else if (i_reg_rd) begin
            case (i_reg_addr)
                REG_ADDR_PKT_COUNT: word_d.count = i_pkt_count;
                REG_ADDR_TRIGGER:   word_d.count = REG_DATA_W'(i_armed);
                REG_ADDR_CAP_LEN:   word_d.count = REG_DATA_W'(i_cap_len);
                default:            word_d.count = '0;
            endcase
        end
    end

    always_ff @(posedge i_clk_stream) begin
        if (load_word) begin
            rdata_q <= word_d;
        end
        if (buf_start) begin
            row_addr_q <= i_reg_addr[BUF_ADDR_W-1:0];
        end
    end

    // buffer read sequence, request until granted then wait for data
    always_ff @(posedge i_clk_stream or negedge i_rst_n) begin
        if (!i_rst_n) begin
            rd_state_q <= RD_IDLE;
            valid_q    <= 1'b0;
        end else begin
            valid_q <= load_word;
            case (rd_state_q)
                RD_IDLE: if (buf_start) rd_state_q <= RD_REQ;
                RD_REQ:  if (o_buf.gnt) rd_state_q <= RD_WAIT;
                RD_WAIT: if (o_buf.rvalid) rd_state_q <= RD_IDLE;
                default: rd_state_q <= RD_IDLE;
            endcase
        end
    end

    assign o_buf.req   = (rd_state_q == RD_REQ);
    assign o_buf.we    = 1'b0;
    assign o_buf.addr  = row_addr_q;
    assign o_buf.wdata = '0;

    assign o_reg_rdata = rdata_q;
    assign o_reg_valid = valid_q;

    a_no_rd_wr: assert property (@(posedge i_clk_stream) disable iff (!i_rst_n)
        !(i_reg_rd && i_reg_wr));

endmodule

//--- hdl/eth_mon_top.sv
`timescale 1ns/1ns

module eth_mon_top (
    input  logic                                  i_clk_stream,
    input  logic                                  i_rst_n,
    input  logic [eth_mon_pkg::STREAM_DATA_W-1:0] i_eths_slave_data,
    input  logic [eth_mon_pkg::STREAM_KEEP_W-1:0] i_eths_slave_keep,
    input  logic                                  i_eths_slave_valid,
    input  logic                                  i_eths_slave_abort,
    input  logic                                  i_eths_slave_last,
    output logic [eth_mon_pkg::STREAM_DATA_W-1:0] o_eths_master_data,
    output logic [eth_mon_pkg::STREAM_KEEP_W-1:0] o_eths_master_keep,
    output logic                                  o_eths_master_valid,
    output logic                                  o_eths_master_abort,
    output logic                                  o_eths_master_last,
    input  logic [eth_mon_pkg::REG_ADDR_W-1:0]    i_reg_addr,
    input  logic                                  i_reg_rd,
    input  logic                                  i_reg_wr,
    output logic [eth_mon_pkg::REG_DATA_W-1:0]    o_reg_rdata,
    output logic                                  o_reg_valid
);
    import eth_mon_pkg::*;

    logic [REG_DATA_W-1:0] pkt_count;
    logic [CAP_LEN_W-1:0]  cap_len;
    logic                  armed;
    logic                  arm;

    eth_stream_if tap_stream ();
    // writer, reader and memory sides of the arbiter
    buf_port_if   wr_port ();
    buf_port_if   rd_port ();
    buf_port_if   mem_port ();

    stream_tap u_stream_tap (
        .i_clk_stream        (i_clk_stream),
        .i_rst_n             (i_rst_n),
        .i_eths_slave_data   (i_eths_slave_data),
        .i_eths_slave_keep   (i_eths_slave_keep),
        .i_eths_slave_valid  (i_eths_slave_valid),
        .i_eths_slave_abort  (i_eths_slave_abort),
        .i_eths_slave_last   (i_eths_slave_last),
        .o_eths_master_data  (o_eths_master_data),
        .o_eths_master_keep  (o_eths_master_keep),
        .o_eths_master_valid (o_eths_master_valid),
        .o_eths_master_abort (o_eths_master_abort),
        .o_eths_master_last  (o_eths_master_last),
        .o_stream            (tap_stream.src),
        .o_pkt_count         (pkt_count)
    );

    capture_ctrl u_capture_ctrl (
        .i_clk_stream (i_clk_stream),
        .i_rst_n      (i_rst_n),
        .i_stream     (tap_stream.snk),
        .o_buf        (wr_port.req_side),
        .i_arm        (arm),
        .o_armed      (armed),
        .o_cap_len    (cap_len)
    );

    buffer_arbiter u_buffer_arbiter (
        .i_clk_stream (i_clk_stream),
        .i_rst_n      (i_rst_n),
        .i_wr         (wr_port.grant_side),
        .i_rd         (rd_port.grant_side),
        .o_mem        (mem_port.req_side)
    );

    capture_buffer u_capture_buffer (
        .i_clk_stream (i_clk_stream),
        .i_port       (mem_port.grant_side)
    );

    reg_access u_reg_access (
        .i_clk_stream (i_clk_stream),
        .i_rst_n      (i_rst_n),
        .i_reg_addr   (i_reg_addr),
        .i_reg_rd     (i_reg_rd),
        .i_reg_wr     (i_reg_wr),
        .o_reg_rdata  (o_reg_rdata),
        .o_reg_valid  (o_reg_valid),
        .i_pkt_count  (pkt_count),
        .i_armed      (armed),
        .i_cap_len    (cap_len),
        .o_arm        (arm),
        .o_buf        (rd_port.req_side)
    );

endmodule

//--- dv/tb_eth_mon.sv
`timescale 1ns/1ns

module tb_eth_mon;
    import eth_mon_pkg::*;

    localparam int CLK_PERIOD  = 8;
    localparam int BEAT_W      = STREAM_DATA_W + STREAM_KEEP_W + 3;
    localparam int REG_TIMEOUT = 100;
    localparam int CAP_POLLS   = 200;

    logic                     i_clk_stream;
    logic                     i_rst_n;
    logic [STREAM_DATA_W-1:0] i_eths_slave_data;
    logic [STREAM_KEEP_W-1:0] i_eths_slave_keep;
    logic                     i_eths_slave_valid;
    logic                     i_eths_slave_abort;
    logic                     i_eths_slave_last;
    logic [STREAM_DATA_W-1:0] o_eths_master_data;
    logic [STREAM_KEEP_W-1:0] o_eths_master_keep;
    logic                     o_eths_master_valid;
    logic                     o_eths_master_abort;
    logic                     o_eths_master_last;
    logic [REG_ADDR_W-1:0]    i_reg_addr;
    logic                     i_reg_rd;
    logic                     i_reg_wr;
    logic [REG_DATA_W-1:0]    o_reg_rdata;
    logic                     o_reg_valid;

    logic [15:0] lfsr_q;
    // every valid beat sent, in order
    buf_row_t    sent_q[$];
    buf_row_t    prev_row;
    logic        prev_valid;
    int          pkt_sent;
    int          cap_first;
    int          cap_len_exp;

    eth_mon_top u_dut (.*);

    initial begin
        i_clk_stream = 1'b0;
        forever #(CLK_PERIOD / 2) i_clk_stream = ~i_clk_stream;
    end

    // x^16 + x^14 + x^13 + x^11 + 1, one step per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] val;
        logic        fb;
        val = '0;
        for (int k = 0; k < n; k++) begin
            fb     = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];
            lfsr_q = {lfsr_q[14:0], fb};
            val    = {val[30:0], fb};
        end
        return val;
    endfunction

    function automatic buf_row_t make_row(input logic last);
        buf_row_t row;
        row.data  = rand_bits(32);
        row.keep  = STREAM_KEEP_W'(rand_bits(2));
        // abort shows up now and then
        row.abort = (rand_bits(3) == 32'd0);
        row.last  = last;
        return row;
    endfunction

    task automatic stop_run(input string why);
        $display("%s", why);
        $display("SIMULATION FAILED");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_value(input string test, input string what,
                               input logic [63:0] expected, input logic [63:0] actual);
        assert (expected == actual) else begin
            stop_run($sformatf("Error: %s %s expected %0h actual %0h",
                               test, what, expected, actual));
        end
    endtask

    // output must show the beat driven one cycle earlier
    task automatic drive_beat(input logic valid, input buf_row_t row);
        logic [BEAT_W-1:0] exp_out;
        logic [BEAT_W-1:0] act_out;
        @(posedge i_clk_stream);
        #1;
        exp_out = {prev_row.data, prev_row.keep, prev_valid, prev_row.abort, prev_row.last};
        act_out = {o_eths_master_data, o_eths_master_keep, o_eths_master_valid,
                   o_eths_master_abort, o_eths_master_last};
        check_value("passthrough", "beat", 64'(exp_out), 64'(act_out));
        i_eths_slave_data  = row.data;
        i_eths_slave_keep  = row.keep;
        i_eths_slave_valid = valid;
        i_eths_slave_abort = row.abort;
        i_eths_slave_last  = row.last;
        prev_row   = row;
        prev_valid = valid;
        if (valid) begin
            sent_q.push_back(row);
        end
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) drive_beat(1'b0, '0);
    endtask

    task automatic send_packet(input int len, output int first_idx);
        first_idx = sent_q.size();
        for (int i = 0; i < len; i++) begin
            drive_beat(1'b1, make_row(i == len - 1));
        end
        pkt_sent++;
    endtask

    task automatic resend_packet(input int first_idx, input int len);
        for (int i = 0; i < len; i++) begin
            drive_beat(1'b1, sent_q[first_idx + i]);
        end
        pkt_sent++;
    endtask

    task automatic wait_response(input logic [REG_ADDR_W-1:0] addr,
                                 output logic [REG_DATA_W-1:0] data);
        int cycles;
        cycles = 0;
        do begin
            @(posedge i_clk_stream);
            #1;
            cycles++;
            if (!o_reg_valid && cycles >= REG_TIMEOUT) begin
                stop_run($sformatf("no register response for address %h", addr));
            end
        end while (!o_reg_valid);
        data = o_reg_rdata;
    endtask

    task automatic reg_read(input logic [REG_ADDR_W-1:0] addr,
                            output logic [REG_DATA_W-1:0] data);
        @(posedge i_clk_stream);
        #1;
        i_reg_addr = addr;
        i_reg_rd   = 1'b1;
        wait_response(addr, data);
        i_reg_rd = 1'b0;
    endtask

    task automatic reg_write(input logic [REG_ADDR_W-1:0] addr);
        logic [REG_DATA_W-1:0] ack_data;
        @(posedge i_clk_stream);
        #1;
        i_reg_addr = addr;
        i_reg_wr   = 1'b1;
        wait_response(addr, ack_data);
        i_reg_wr = 1'b0;
    endtask

    task automatic wait_capture_done(input string test);
        logic [REG_DATA_W-1:0] data;
        int polls;
        polls = 0;
        do begin
            reg_read(REG_ADDR_TRIGGER, data);
            polls++;
            if (data != '0 && polls >= CAP_POLLS) begin
                stop_run($sformatf("%s: capture did not finish, trigger still armed", test));
            end
        end while (data != '0);
    endtask

    task automatic test_reset_state();
        logic [REG_DATA_W-1:0] data;
        check_value("reset", "valid", 64'd0, 64'(o_eths_master_valid));
        check_value("reset", "last", 64'd0, 64'(o_eths_master_last));
        check_value("reset", "abort", 64'd0, 64'(o_eths_master_abort));
        check_value("reset", "reg_valid", 64'd0, 64'(o_reg_valid));
        reg_read(REG_ADDR_PKT_COUNT, data);
        check_value("reset", "count", 64'd0, 64'(data));
        reg_read(REG_ADDR_TRIGGER, data);
        check_value("reset", "trigger", 64'd0, 64'(data));
        reg_read(REG_ADDR_CAP_LEN, data);
        check_value("reset", "length", 64'd0, 64'(data));
    endtask

    task automatic test_passthrough();
        int idx;
        repeat (3) begin
            send_packet(1 + int'(rand_bits(3)), idx);
            idle_cycles(1);
        end
        idle_cycles(2);
    endtask

    task automatic test_packet_count();
        logic [REG_DATA_W-1:0] data;
        int idx;
        // back to back, no gap between packets
        repeat (5) send_packet(1 + int'(rand_bits(4)), idx);
        idle_cycles(3);
        reg_read(REG_ADDR_PKT_COUNT, data);
        check_value("packet_count", "count", 64'(pkt_sent), 64'(data));
    endtask

    task automatic test_trigger_length();
        logic [REG_DATA_W-1:0] data;
        reg_write(REG_ADDR_TRIGGER);
        reg_read(REG_ADDR_TRIGGER, data);
        check_value("trigger_length", "armed", 64'd1, 64'(data));
        cap_len_exp = 1 + int'(rand_bits(6));
        send_packet(cap_len_exp, cap_first);
        idle_cycles(2);
        wait_capture_done("trigger_length");
        reg_read(REG_ADDR_CAP_LEN, data);
        check_value("trigger_length", "length", 64'(cap_len_exp), 64'(data));
    endtask

    task automatic test_readback();
        logic [REG_DATA_W-1:0] data;
        reg_word_u word;
        int idx;
        reg_write(REG_ADDR_TRIGGER);
        fork
            begin
                // same beats again, so rewritten rows keep their values
                resend_packet(cap_first, cap_len_exp);
                repeat (3) send_packet(2 + int'(rand_bits(4)), idx);
                idle_cycles(3);
            end
            begin
                for (int i = 0; i < cap_len_exp; i++) begin
                    reg_read(16'h8000 | REG_ADDR_W'(i), data);
                    word = data;
                    check_value("readback", "pad", 64'd0, 64'(word.row_view.pad));
                    check_value("readback", "row", 64'(sent_q[cap_first + i]),
                                64'(word.row_view.row));
                end
            end
        join
        wait_capture_done("readback");
        reg_read(REG_ADDR_CAP_LEN, data);
        check_value("readback", "length", 64'(cap_len_exp), 64'(data));
    endtask

    task automatic test_idle_wait();
        logic [REG_DATA_W-1:0] data;
        reg_word_u word;
        int a_first;
        int b_first;
        int b_len;
        b_len = 2 + int'(rand_bits(5));
        fork
            begin
                send_packet(24, a_first);
                send_packet(b_len, b_first);
                idle_cycles(3);
            end
            begin
                // arm well inside the first packet
                repeat (6) @(posedge i_clk_stream);
                reg_write(REG_ADDR_TRIGGER);
            end
        join
        wait_capture_done("idle_wait");
        reg_read(REG_ADDR_CAP_LEN, data);
        check_value("idle_wait", "length", 64'(b_len), 64'(data));
        reg_read(16'h8000, data);
        word = data;
        check_value("idle_wait", "first row", 64'(sent_q[b_first]), 64'(word.row_view.row));
    endtask

    task automatic test_unmapped();
        logic [REG_DATA_W-1:0] data;
        reg_read(16'h0003, data);
        check_value("unmapped", "read", 64'd0, 64'(data));
        reg_write(16'h0003);
        reg_read(REG_ADDR_TRIGGER, data);
        check_value("unmapped", "trigger", 64'd0, 64'(data));
    endtask

    initial begin
        i_rst_n            = 1'b0;
        i_eths_slave_data  = '0;
        i_eths_slave_keep  = '0;
        i_eths_slave_valid = 1'b0;
        i_eths_slave_abort = 1'b0;
        i_eths_slave_last  = 1'b0;
        i_reg_addr         = '0;
        i_reg_rd           = 1'b0;
        i_reg_wr           = 1'b0;
        lfsr_q             = 16'd11;
        prev_row           = '0;
        prev_valid         = 1'b0;
        pkt_sent           = 0;
        repeat (3) @(posedge i_clk_stream);
        #1;
        i_rst_n = 1'b1;
        test_reset_state();
        test_passthrough();
        test_packet_count();
        test_trigger_length();
        test_readback();
        test_idle_wait();
        test_unmapped();
        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

//--- list.f
hdl/eth_mon_pkg.sv
hdl/eth_mon_ifs.sv
hdl/stream_tap.sv
hdl/capture_ctrl.sv
hdl/buffer_arbiter.sv
hdl/capture_buffer.sv
hdl/reg_access.sv
hdl/eth_mon_top.sv
dv/tb_eth_mon.sv

//--- Makefile
TOP := tb_eth_mon
LOG := sim.log

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f list.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -Wno-fatal -f list.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "SIMULATION PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
